// ==== rtl/line_fill_pkg.sv ====
// Line fill engine shared constants: system bus, tags, line geometry and APB register map
`default_nettype none

package line_fill_pkg;

    // ########################################
    // System bus
    // ########################################
    localparam bus_data_width = 64;
    localparam bus_tag_width = 13;

    // Tag fields: request kind at bit 12, target in bits 11 to 8
    localparam logic [0:0] sysbus_read = 1'b1;
    localparam logic [3:0] sysbus_memory = 4'd1;
    localparam logic [bus_tag_width-1:0] read_mem_tag = {sysbus_read, sysbus_memory, 8'h00};

    // ########################################
    // Line geometry
    // ########################################
    localparam beats_per_line = 8;
    localparam beat_index_width = 3;
    localparam line_offset_bits = 6;

    // Fetch sequencer state codes
    localparam fetch_state_width = 3;
    localparam logic [fetch_state_width-1:0] fetch_idle = 3'd0;
    localparam logic [fetch_state_width-1:0] fetch_arbitrate = 3'd1;
    localparam logic [fetch_state_width-1:0] fetch_request = 3'd2;
    localparam logic [fetch_state_width-1:0] fetch_collect = 3'd3;
    localparam logic [fetch_state_width-1:0] fetch_done = 3'd4;

    // ########################################
    // APB register map
    // ########################################
    localparam apb_addr_width = 8;
    localparam apb_data_width = 32;
    localparam logic [apb_addr_width-1:0] reg_addr_lo = 8'h00;
    localparam logic [apb_addr_width-1:0] reg_addr_hi = 8'h04;
    localparam logic [apb_addr_width-1:0] reg_ctrl = 8'h08;
    localparam logic [apb_addr_width-1:0] reg_status = 8'h0C;
    localparam logic [apb_addr_width-1:0] reg_line_base = 8'h40;
    localparam line_word_count = 16;
    localparam word_index_width = 4;
    localparam foreign_count_width = 8;

endpackage

`default_nettype wire

// ==== rtl/apb_reg_decode.sv ====
// APB register decoder holding the fill address, status flags and foreign beat count
`default_nettype none
`timescale 1ns/1ns

module apb_reg_decode
(
    input  wire                                       clk,
    input  wire                                       reset,
    input  wire                                       psel,
    input  wire                                       penable,
    input  wire                                       pwrite,
    input  wire [line_fill_pkg::apb_addr_width-1:0]   paddr,
    input  wire [line_fill_pkg::apb_data_width-1:0]   pwdata,
    input  wire                                       fill_busy,
    input  wire                                       fill_done,
    input  wire                                       foreign_beat,
    input  wire [line_fill_pkg::apb_data_width-1:0]   rd_word,
    output logic [line_fill_pkg::apb_data_width-1:0]  prdata,
    output logic                                      pready,
    output logic                                      pslverr,
    output logic                                      fill_start,
    output logic [line_fill_pkg::bus_data_width-1:0]  fill_addr,
    output logic [line_fill_pkg::word_index_width-1:0] rd_word_index
);

    logic [line_fill_pkg::apb_data_width-1:0]      addr_lo;
    logic [line_fill_pkg::apb_data_width-1:0]      addr_hi;
    logic                                          done_flag;
    logic [line_fill_pkg::foreign_count_width-1:0] foreign_count;

    logic apb_access;
    logic apb_write;
    logic sel_addr_lo;
    logic sel_addr_hi;
    logic sel_ctrl;
    logic sel_status;
    logic sel_line;
    logic mapped;
    logic start_hit;

    // ########################################
    // Address decode
    // ########################################
    assign apb_access = psel & penable;
    assign apb_write = apb_access & pwrite;

    assign sel_addr_lo = (paddr == line_fill_pkg::reg_addr_lo);
    assign sel_addr_hi = (paddr == line_fill_pkg::reg_addr_hi);
    assign sel_ctrl = (paddr == line_fill_pkg::reg_ctrl);
    assign sel_status = (paddr == line_fill_pkg::reg_status);

    // The line window spans one 64-byte block of word-aligned addresses
    assign sel_line =
        (paddr[line_fill_pkg::apb_addr_width-1:line_fill_pkg::line_offset_bits] ==
         line_fill_pkg::reg_line_base[line_fill_pkg::apb_addr_width-1:
                                      line_fill_pkg::line_offset_bits]) &&
        (paddr[1:0] == 2'b00);

    assign mapped = sel_addr_lo | sel_addr_hi | sel_ctrl | sel_status | sel_line;

    // A start while busy is dropped here, so the fetcher never sees it
    assign start_hit = apb_write & sel_ctrl & pwdata[0] & ~fill_busy;

    assign rd_word_index = paddr[line_fill_pkg::word_index_width+1:2];
    assign fill_addr = {addr_hi, addr_lo};

    // ########################################
    // APB response
    // ########################################
    assign pready = 1'b1;
    assign pslverr = apb_access & (~mapped | (pwrite & (sel_status | sel_line)));

    always_comb
    begin
        prdata = '0;
        if (sel_addr_lo)
        begin
            prdata = addr_lo;
        end
        else if (sel_addr_hi)
        begin
            prdata = addr_hi;
        end
        else if (sel_status)
        begin
            prdata[0] = fill_busy;
            prdata[1] = done_flag;
            prdata[15:8] = foreign_count;
        end
        else if (sel_line)
        begin
            prdata = rd_word;
        end
    end

    // ########################################
    // Registers
    // ########################################
    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            addr_lo <= '0;
            addr_hi <= '0;
            done_flag <= 1'b0;
            foreign_count <= '0;
            fill_start <= 1'b0;
        end
        else
        begin
            fill_start <= start_hit;
            if (apb_write && sel_addr_lo)
            begin
                addr_lo <= pwdata;
            end
            if (apb_write && sel_addr_hi)
            begin
                addr_hi <= pwdata;
            end
            // A new fill starts with a clean done flag and count
            if (start_hit)
            begin
                done_flag <= 1'b0;
                foreign_count <= '0;
            end
            else
            begin
                if (fill_done)
                begin
                    done_flag <= 1'b1;
                end
                if (foreign_beat && (foreign_count != '1))
                begin
                    foreign_count <= foreign_count + 1'b1;
                end
            end
        end
    end

endmodule

`default_nettype wire

// ==== rtl/line_fetcher.sv ====
// Fill sequencer that arbitrates for the system bus, reads one line and counts its beats
`default_nettype none
`timescale 1ns/1ns

module line_fetcher
(
    input  wire                                          clk,
    input  wire                                          reset,
    input  wire                                          fill_start,
    input  wire [line_fill_pkg::bus_data_width-1:0]      fill_addr,
    input  wire                                          abtr_grant,
    input  wire                                          main_bus_respcyc,
    input  wire [line_fill_pkg::bus_data_width-1:0]      main_bus_resp,
    input  wire [line_fill_pkg::bus_tag_width-1:0]       main_bus_resptag,
    output logic                                         abtr_reqcyc,
    output logic                                         main_bus_reqcyc,
    output logic [line_fill_pkg::bus_data_width-1:0]     main_bus_req,
    output logic [line_fill_pkg::bus_tag_width-1:0]      main_bus_reqtag,
    output logic                                         main_bus_respack,
    output logic                                         fill_busy,
    output logic                                         fill_done,
    output logic                                         foreign_beat,
    output logic                                         beat_wr_en,
    output logic [line_fill_pkg::beat_index_width-1:0]   beat_index,
    output logic [line_fill_pkg::bus_data_width-1:0]     beat_data
);

    logic [line_fill_pkg::fetch_state_width-1:0] state;
    logic [line_fill_pkg::fetch_state_width-1:0] next_state;
    logic [line_fill_pkg::bus_data_width-1:0]    line_addr;
    logic [line_fill_pkg::beat_index_width-1:0]  beat_count;

    logic collecting;
    logic beat_taken;
    logic tag_match;
    logic last_beat;

    // ########################################
    // Beat qualification
    // ########################################
    assign collecting = (state == line_fill_pkg::fetch_collect);
    assign beat_taken = collecting & main_bus_respcyc;
    assign tag_match = (main_bus_resptag == line_fill_pkg::read_mem_tag);
    assign last_beat =
        (beat_count == line_fill_pkg::beat_index_width'(line_fill_pkg::beats_per_line - 1));

    assign beat_wr_en = beat_taken & tag_match;
    assign foreign_beat = beat_taken & ~tag_match;
    assign beat_index = beat_count;
    assign beat_data = main_bus_resp;

    // ########################################
    // Bus outputs
    // ########################################
    assign abtr_reqcyc = (state == line_fill_pkg::fetch_arbitrate);
    assign main_bus_reqcyc = (state == line_fill_pkg::fetch_request);
    assign main_bus_req = line_addr;
    assign main_bus_reqtag = line_fill_pkg::read_mem_tag;
    assign main_bus_respack = collecting;

    assign fill_busy = (state == line_fill_pkg::fetch_arbitrate) ||
                       (state == line_fill_pkg::fetch_request) ||
                       collecting;
    assign fill_done = (state == line_fill_pkg::fetch_done);

    // ########################################
    // Next state
    // ########################################
    always_comb
    begin
        next_state = state;
        case (state)
            line_fill_pkg::fetch_idle:
            begin
                if (fill_start)
                begin
                    next_state = line_fill_pkg::fetch_arbitrate;
                end
            end
            line_fill_pkg::fetch_arbitrate:
            begin
                // Hold the arbiter request for as long as the grant stays low
                if (abtr_grant)
                begin
                    next_state = line_fill_pkg::fetch_request;
                end
            end
            line_fill_pkg::fetch_request:
            begin
                next_state = line_fill_pkg::fetch_collect;
            end
            line_fill_pkg::fetch_collect:
            begin
                if (beat_wr_en && last_beat)
                begin
                    next_state = line_fill_pkg::fetch_done;
                end
            end
            line_fill_pkg::fetch_done:
            begin
                next_state = fill_start ? line_fill_pkg::fetch_arbitrate
                                        : line_fill_pkg::fetch_idle;
            end
            default:
            begin
                next_state = line_fill_pkg::fetch_idle;
            end
        endcase
    end

    // ########################################
    // State, address latch and beat counter
    // ########################################
    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            state <= line_fill_pkg::fetch_idle;
            beat_count <= '0;
        end
        else
        begin
            state <= next_state;
            if (fill_start && !fill_busy)
            begin
                beat_count <= '0;
            end
            else if (beat_wr_en)
            begin
                beat_count <= beat_count + 1'b1;
            end
        end
    end

    // Request address is the start of the line holding fill_addr
    always_ff @(posedge clk)
    begin
        if (fill_start && !fill_busy)
        begin
            line_addr <= {fill_addr[line_fill_pkg::bus_data_width-1:
                                    line_fill_pkg::line_offset_bits],
                          {line_fill_pkg::line_offset_bits{1'b0}}};
        end
    end

endmodule

`default_nettype wire

// ==== rtl/line_buffer.sv ====
// Line store of eight 64-bit beats, written per beat and read per 32-bit word
`default_nettype none
`timescale 1ns/1ns

module line_buffer
(
    input  wire                                          clk,
    input  wire                                          reset,
    input  wire                                          beat_wr_en,
    input  wire [line_fill_pkg::beat_index_width-1:0]    beat_index,
    input  wire [line_fill_pkg::bus_data_width-1:0]      beat_data,
    input  wire [line_fill_pkg::word_index_width-1:0]    rd_word_index,
    output logic [line_fill_pkg::apb_data_width-1:0]     rd_word
);

    logic [line_fill_pkg::bus_data_width-1:0] entries [line_fill_pkg::beats_per_line];
    logic [line_fill_pkg::bus_data_width-1:0] rd_entry;

    // ########################################
    // Beat writes
    // ########################################
    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            for (int i = 0; i < line_fill_pkg::beats_per_line; i++)
            begin
                entries[i] <= '0;
            end
        end
        else if (beat_wr_en)
        begin
            entries[beat_index] <= beat_data;
        end
    end

    // ########################################
    // Word reads
    // ########################################
    // Two words per beat, the even word in the low half
    assign rd_entry = entries[rd_word_index[line_fill_pkg::word_index_width-1:1]];

    always_comb
    begin
        if (rd_word_index[0])
        begin
            rd_word = rd_entry[line_fill_pkg::bus_data_width-1:line_fill_pkg::apb_data_width];
        end
        else
        begin
            rd_word = rd_entry[line_fill_pkg::apb_data_width-1:0];
        end
    end

endmodule

`default_nettype wire

// ==== rtl/line_fill_top.sv ====
// Line fill engine top joining the APB decoder, bus fetcher and line buffer
`default_nettype none
`timescale 1ns/1ns

module line_fill_top
(
    input  wire                                       clk,
    input  wire                                       reset,
    // APB slave
    input  wire                                       psel,
    input  wire                                       penable,
    input  wire                                       pwrite,
    input  wire [line_fill_pkg::apb_addr_width-1:0]   paddr,
    input  wire [line_fill_pkg::apb_data_width-1:0]   pwdata,
    output wire [line_fill_pkg::apb_data_width-1:0]   prdata,
    output wire                                       pready,
    output wire                                       pslverr,
    // System bus arbiter
    output wire                                       abtr_reqcyc,
    input  wire                                       abtr_grant,
    // System bus request and response
    output wire                                       main_bus_reqcyc,
    output wire [line_fill_pkg::bus_data_width-1:0]   main_bus_req,
    output wire [line_fill_pkg::bus_tag_width-1:0]    main_bus_reqtag,
    input  wire                                       main_bus_respcyc,
    input  wire [line_fill_pkg::bus_data_width-1:0]   main_bus_resp,
    input  wire [line_fill_pkg::bus_tag_width-1:0]    main_bus_resptag,
    output wire                                       main_bus_respack
);

    wire                                          fill_start;
    wire [line_fill_pkg::bus_data_width-1:0]      fill_addr;
    wire                                          fill_busy;
    wire                                          fill_done;
    wire                                          foreign_beat;
    wire                                          beat_wr_en;
    wire [line_fill_pkg::beat_index_width-1:0]    beat_index;
    wire [line_fill_pkg::bus_data_width-1:0]      beat_data;
    wire [line_fill_pkg::word_index_width-1:0]    rd_word_index;
    wire [line_fill_pkg::apb_data_width-1:0]      rd_word;

    // ########################################
    // Decode, execute and result stages
    // ########################################
    apb_reg_decode u_decode (
        .clk(clk), .reset(reset),
        .psel(psel), .penable(penable), .pwrite(pwrite), .paddr(paddr), .pwdata(pwdata),
        .fill_busy(fill_busy), .fill_done(fill_done), .foreign_beat(foreign_beat),
        .rd_word(rd_word),
        .prdata(prdata), .pready(pready), .pslverr(pslverr),
        .fill_start(fill_start), .fill_addr(fill_addr), .rd_word_index(rd_word_index)
    );

    line_fetcher u_fetch (
        .clk(clk), .reset(reset),
        .fill_start(fill_start), .fill_addr(fill_addr),
        .abtr_grant(abtr_grant),
        .main_bus_respcyc(main_bus_respcyc), .main_bus_resp(main_bus_resp),
        .main_bus_resptag(main_bus_resptag),
        .abtr_reqcyc(abtr_reqcyc),
        .main_bus_reqcyc(main_bus_reqcyc), .main_bus_req(main_bus_req),
        .main_bus_reqtag(main_bus_reqtag), .main_bus_respack(main_bus_respack),
        .fill_busy(fill_busy), .fill_done(fill_done), .foreign_beat(foreign_beat),
        .beat_wr_en(beat_wr_en), .beat_index(beat_index), .beat_data(beat_data)
    );

    line_buffer u_buffer (
        .clk(clk), .reset(reset),
        .beat_wr_en(beat_wr_en), .beat_index(beat_index), .beat_data(beat_data),
        .rd_word_index(rd_word_index), .rd_word(rd_word)
    );

endmodule

`default_nettype wire

// ==== test/expected_beat.svh ====
// Line data pattern that the memory model returns and the testbench checks against
function automatic logic [63:0] expected_beat(
    input logic [63:0] base,
    input logic [2:0]  index
);
    logic [63:0] k;
    k = {61'd0, index};
    return (base ^ (k * 64'h9E37_79B9_7F4A_7C15)) + k;
endfunction

// ==== test/sysbus_memory_model.sv ====
// System bus arbiter and memory model with random grant delay, beat gaps and foreign-tag beats
`default_nettype none
`timescale 1ns/1ns

module sysbus_memory_model
(
    input  wire         clk,
    input  wire         reset,
    input  wire [3:0]   foreign_beats,
    input  wire         abtr_reqcyc,
    output logic        abtr_grant,
    input  wire         main_bus_reqcyc,
    input  wire [63:0]  main_bus_req,
    output logic        main_bus_respcyc,
    output logic [63:0] main_bus_resp,
    output logic [12:0] main_bus_resptag,
    input  wire         main_bus_respack
);

    int seed;

    `include "expected_beat.svh"

    // One response beat after a random idle gap of up to three cycles
    task automatic send_beat(input logic [63:0] data, input logic [12:0] tag);
        int gap;
        gap = $random(seed) & 3;
        repeat (gap)
        begin
            @(posedge clk);
            main_bus_respcyc <= 1'b0;
        end
        @(posedge clk);
        main_bus_respcyc <= 1'b1;
        main_bus_resp <= data;
        main_bus_resptag <= tag;
    endtask

    task automatic serve_fill();
        logic [63:0] line_addr;
        int delay;
        int foreign_left;
        delay = $random(seed) & 7;
        repeat (delay) @(posedge clk);
        @(posedge clk);
        abtr_grant <= 1'b1;
        @(posedge clk);
        abtr_grant <= 1'b0;
        do
        begin
            @(negedge clk);
        end
        while (!main_bus_reqcyc);
        line_addr = main_bus_req;
        while (!main_bus_respack) @(negedge clk);
        foreign_left = 32'(foreign_beats);
        for (int beat = 0; beat < line_fill_pkg::beats_per_line; beat++)
        begin
            // Foreign beats all go out before the last line beat, while respack is still high
            while (foreign_left > 0 &&
                   (beat == line_fill_pkg::beats_per_line - 1 || ($random(seed) & 1) != 0))
            begin
                send_beat(~expected_beat(line_addr, 3'(beat)),
                          line_fill_pkg::read_mem_tag ^ 13'h1000);
                foreign_left--;
            end
            send_beat(expected_beat(line_addr, 3'(beat)), line_fill_pkg::read_mem_tag);
        end
        @(posedge clk);
        main_bus_respcyc <= 1'b0;
    endtask

    initial
    begin
        seed = 32'h5755_0bc1;
        abtr_grant <= 1'b0;
        main_bus_respcyc <= 1'b0;
        main_bus_resp <= '0;
        main_bus_resptag <= '0;
        forever
        begin
            @(negedge clk);
            if (!reset && abtr_reqcyc)
            begin
                serve_fill();
            end
        end
    end

endmodule

`default_nettype wire

// ==== test/line_fill_tb.sv ====
// Testbench for the line fill engine with an APB host and a system bus memory model
`default_nettype none
`timescale 1ns/1ns

module line_fill_tb;

    logic        clk;
    logic        reset;
    logic        psel;
    logic        penable;
    logic        pwrite;
    logic [7:0]  paddr;
    logic [31:0] pwdata;
    logic [3:0]  foreign_beats;
    wire  [31:0] prdata;
    wire         pready;
    wire         pslverr;
    wire         abtr_reqcyc;
    wire         abtr_grant;
    wire         main_bus_reqcyc;
    wire  [63:0] main_bus_req;
    wire  [12:0] main_bus_reqtag;
    wire         main_bus_respcyc;
    wire  [63:0] main_bus_resp;
    wire  [12:0] main_bus_resptag;
    wire         main_bus_respack;

    int          seed;
    int          error_count = 0;
    int          test_count = 0;
    int          test_start_errors = 0;
    int          fill_count = 0;
    int          request_count = 0;
    logic [63:0] line_addr = '0;
    logic        arb_waiting = 1'b0;
    logic        arb_granted = 1'b0;
    logic        ack_expected = 1'b0;
    int          matched_beats = 0;

    line_fill_top DUT (.*);
    sysbus_memory_model memory (.*);

    `include "expected_beat.svh"

    initial
    begin
        clk = 1'b0;
        forever
        begin
            #5 clk = ~clk;
        end
    end

    // Twenty fills of two hundred cycles each
    initial
    begin
        #(20 * 200 * 10);
        $display("Timeout: the run did not finish within %0d cycles", 20 * 200);
        $display("TEST FAIL");
        $finish;
    end

    // ########################################
    // Reference and compare
    // ########################################
    function automatic logic [31:0] expected_word(input logic [63:0] addr, input int word);
        logic [63:0] beat;
        beat = expected_beat({addr[63:6], 6'b0}, word[3:1]);
        return word[0] ? beat[63:32] : beat[31:0];
    endfunction

    task automatic check_value(input string name, input logic [63:0] expected,
                               input logic [63:0] actual);
        if (expected !== actual)
        begin
            $display("ERROR %s expected %h actual %h", name, expected, actual);
            error_count++;
        end
    endtask

    task automatic end_test(input string name);
        test_count++;
        $display("test %0d %s: %s", test_count, name,
                 (error_count == test_start_errors) ? "passed" : "failed");
        test_start_errors = error_count;
    endtask

    // Arbiter, request and response handshakes, and every request's address and tag
    always @(negedge clk)
    begin
        if (reset)
        begin
            check_value("arbiter request in reset", 64'd0, 64'(abtr_reqcyc));
            check_value("bus request in reset", 64'd0, 64'(main_bus_reqcyc));
            check_value("response ack in reset", 64'd0, 64'(main_bus_respack));
            arb_waiting = 1'b0;
            arb_granted = 1'b0;
            ack_expected = 1'b0;
            matched_beats = 0;
        end
        else
        begin
            if (arb_waiting)
            begin
                check_value("arbiter request held", 64'd1, 64'(abtr_reqcyc));
            end
            if (arb_granted)
            begin
                check_value("arbiter request after grant", 64'd0, 64'(abtr_reqcyc));
                check_value("bus request after grant", 64'd1, 64'(main_bus_reqcyc));
            end
            check_value("response ack", 64'(ack_expected), 64'(main_bus_respack));
            arb_waiting = abtr_reqcyc & ~abtr_grant;
            arb_granted = abtr_reqcyc & abtr_grant;
            if (main_bus_reqcyc)
            begin
                request_count++;
                check_value("request address", line_addr, main_bus_req);
                check_value("request tag", 64'(line_fill_pkg::read_mem_tag),
                            64'(main_bus_reqtag));
                ack_expected = 1'b1;
                matched_beats = 0;
            end
            else if (ack_expected && main_bus_respcyc &&
                     main_bus_resptag == line_fill_pkg::read_mem_tag)
            begin
                // The ack drops once the eighth line beat has been taken
                matched_beats++;
                if (matched_beats == line_fill_pkg::beats_per_line)
                begin
                    ack_expected = 1'b0;
                end
            end
        end
    end

    // ########################################
    // APB host
    // ########################################
    task automatic apb_access(input logic write, input logic [7:0] addr, input logic [31:0] wdata,
                              output logic [31:0] rdata, output logic err);
        psel <= 1'b1;
        penable <= 1'b0;
        pwrite <= write;
        paddr <= addr;
        pwdata <= wdata;
        @(posedge clk);
        penable <= 1'b1;
        @(negedge clk);
        rdata = prdata;
        err = pslverr;
        check_value("pready", 64'd1, 64'(pready));
        @(posedge clk);
        psel <= 1'b0;
        penable <= 1'b0;
    endtask

    task automatic apb_write(input logic [7:0] addr, input logic [31:0] data);
        logic [31:0] rdata;
        logic err;
        apb_access(1'b1, addr, data, rdata, err);
        check_value($sformatf("pslverr on write %h", addr), 64'd0, 64'(err));
    endtask

    task automatic apb_read(input logic [7:0] addr, output logic [31:0] data);
        logic err;
        apb_access(1'b0, addr, 32'd0, data, err);
        check_value($sformatf("pslverr on read %h", addr), 64'd0, 64'(err));
    endtask

    // ########################################
    // Fill sequences
    // ########################################
    task automatic check_line(input logic [63:0] addr, input logic blank);
        logic [31:0] word;
        for (int w = 0; w < line_fill_pkg::line_word_count; w++)
        begin
            apb_read(line_fill_pkg::reg_line_base + 8'(4 * w), word);
            check_value($sformatf("line word %0d", w),
                        blank ? 64'd0 : 64'(expected_word(addr, w)), 64'(word));
        end
    endtask

    task automatic run_fill(input logic [63:0] addr, input logic [3:0] foreign,
                            input logic second_start);
        logic [31:0] status;
        foreign_beats <= foreign;
        line_addr = {addr[63:6], 6'b0};
        fill_count++;
        apb_write(line_fill_pkg::reg_addr_lo, addr[31:0]);
        apb_write(line_fill_pkg::reg_addr_hi, addr[63:32]);
        apb_write(line_fill_pkg::reg_ctrl, 32'd1);
        // The engine is busy by now, so this start has to be dropped
        if (second_start)
        begin
            apb_write(line_fill_pkg::reg_ctrl, 32'd1);
        end
        apb_read(line_fill_pkg::reg_status, status);
        check_value("done and count after start", 64'd0, 64'(status[15:1]));
        while (!status[1])
        begin
            apb_read(line_fill_pkg::reg_status, status);
        end
        check_value("status after fill", 64'({foreign, 8'h02}), 64'(status));
        check_value("requests seen", 64'(fill_count), 64'(request_count));
        check_line(addr, 1'b0);
    endtask

    initial
    begin
        logic [63:0] addr;
        logic [31:0] rdata;
        logic err;
        seed = 32'h5755_0bc1;
        reset <= 1'b1;
        psel <= 1'b0;
        penable <= 1'b0;
        pwrite <= 1'b0;
        paddr <= '0;
        pwdata <= '0;
        foreign_beats <= '0;
        repeat (16) @(posedge clk);
        reset <= 1'b0;

        apb_read(line_fill_pkg::reg_status, rdata);
        check_value("status after reset", 64'd0, 64'(rdata));
        check_line(64'd0, 1'b1);
        end_test("reset state");

        addr = {$random(seed), $random(seed)};
        addr[5:0] = 6'd0;
        run_fill(addr, 4'd0, 1'b0);
        end_test("aligned fill");

        addr = {$random(seed), $random(seed)};
        addr[5:0] = 6'h2c;
        run_fill(addr, 4'd0, 1'b0);
        end_test("unaligned fill");

        addr = {$random(seed), $random(seed)};
        run_fill(addr, 4'd5, 1'b0);
        end_test("foreign beats");

        addr = {$random(seed), $random(seed)};
        run_fill(addr, 4'd0, 1'b1);
        end_test("start while busy");

        apb_access(1'b0, 8'h10, 32'd0, rdata, err);
        check_value("unmapped read", 64'd1, 64'(err));
        apb_access(1'b1, 8'h3c, 32'd1, rdata, err);
        check_value("unmapped write", 64'd1, 64'(err));
        apb_access(1'b1, line_fill_pkg::reg_status, 32'hff, rdata, err);
        check_value("status write", 64'd1, 64'(err));
        apb_access(1'b1, 8'h48, 32'd1, rdata, err);
        check_value("line window write", 64'd1, 64'(err));
        apb_access(1'b0, 8'h42, 32'd0, rdata, err);
        check_value("unaligned line read", 64'd1, 64'(err));
        end_test("bus errors");

        $display("%0d tests, %0d errors", test_count, error_count);
        if (error_count == 0)
        begin
            $display("TEST PASS");
        end
        else
        begin
            $display("TEST FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== verilog.f ====
+incdir+test
rtl/line_fill_pkg.sv
rtl/apb_reg_decode.sv
rtl/line_fetcher.sv
rtl/line_buffer.sv
rtl/line_fill_top.sv
test/sysbus_memory_model.sv
test/line_fill_tb.sv

// ==== Makefile ====
TOOL      = verilator
FLAGS     = --binary --timing -j 0
LINTFLAGS = --lint-only -Wall --timing
TOP       = line_fill_tb
FILELIST  = verilog.f
BUILD_DIR = obj_dir

.PHONY: all build run lint clean

all: run

build:
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)

# The run passes only if the pass message shows up as a line of its own
run: build
	@out="$$(./$(BUILD_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "TEST PASS"

lint:
	$(TOOL) $(LINTFLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(BUILD_DIR)
